/* imuldiv_pkg.sv */
// types shared by the iterative multiply/divide unit
// function code 2'd3 is unused and is handled as an unsigned divide
package imuldiv_pkg;

  // ------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------

  // one operand or partial result
  typedef logic [31:0] word_t;

  // full product or remainder/quotient pair
  typedef logic [63:0] dword_t;

  // ------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------

  typedef logic [1:0] fn_t;

  localparam fn_t FN_MUL  = 2'd0;  // signed multiply
  localparam fn_t FN_DIV  = 2'd1;  // signed divide
  localparam fn_t FN_DIVU = 2'd2;  // unsigned divide

  // ------------------------------------------------------------
  // messages
  // ------------------------------------------------------------

  // 66 bits, fn in the top two bits
  typedef struct packed {
    fn_t   fn;
    word_t a;
    word_t b;
  } muldiv_req_t;

  // divide puts remainder in [63:32] and quotient in [31:0]
  typedef struct packed {
    dword_t result;
  } muldiv_resp_t;

  // iteration FSM states, shared by both ctrl blocks
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_t;

endpackage

/* imuldiv_mul_ctrl.sv */
// multiplier control, one operation at a time
// accept edge seeds bit 0, then 31 shift/add cycles, then hold in DONE
module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic mul_req_val,
  output logic mul_req_rdy,
  output logic mul_resp_val,
  input  logic mul_resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);
  import imuldiv_pkg::*;

  iter_state_t state;
  logic [4:0]  count;
  logic        req_go;
  logic        resp_go;

  // handshakes seen by this unit
  assign req_go  = mul_req_val & mul_req_rdy;
  assign resp_go = mul_resp_val & mul_resp_rdy;

  // ------------------------------------------------------------
  // state and iteration count
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // count 0..30 covers product bits 1..31
          if (count == 5'd30) begin
            state <= ST_DONE;
          end else begin
            count <= count + 5'd1;
          end
        end
        ST_DONE: begin
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath enables and handshake outputs
  // ------------------------------------------------------------
  always_comb begin
    mul_req_rdy  = 1'b0;
    mul_resp_val = 1'b0;
    a_en         = 1'b0;
    a_mux_sel    = 1'b0;
    b_en         = 1'b0;
    b_mux_sel    = 1'b0;
    case (state)
      ST_IDLE: begin
        mul_req_rdy = 1'b1;
        // sel 0 picks the fresh operand magnitudes
        a_en        = req_go;
        b_en        = req_go;
      end
      ST_CALC: begin
        // shift every cycle, sel 1 picks the shifted registers
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      ST_DONE: mul_resp_val = 1'b1;
      default: mul_req_rdy = 1'b0;
    endcase
  end

endmodule

/* imuldiv_mul_dpath.sv */
// signed 32x32 shift/add multiplier datapath working on magnitudes
// result is valid only while the ctrl block sits in DONE
module imuldiv_mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  a,
  input  imuldiv_pkg::word_t  b,
  input  logic                a_en,
  input  logic                a_mux_sel,
  input  logic                b_en,
  input  logic                b_mux_sel,
  output imuldiv_pkg::dword_t mul_result
);
  import imuldiv_pkg::*;

  // operand magnitudes straight from the request
  word_t  a_mag;
  word_t  b_mag;

  // iteration registers
  dword_t a_reg;
  word_t  b_reg;
  dword_t prod_reg;
  logic   sign_a_reg;
  logic   sign_b_reg;

  dword_t a_next;
  word_t  b_next;
  dword_t prod_seed;
  dword_t prod_acc;
  logic   load_cycle;
  logic   calc_cycle;

  assign a_mag = a[31] ? (~a + 32'd1) : a;
  assign b_mag = b[31] ? (~b + 32'd1) : b;

  assign load_cycle = a_en & ~a_mux_sel;
  assign calc_cycle = a_en & a_mux_sel;

  // ------------------------------------------------------------
  // shift registers
  // ------------------------------------------------------------

  // load cycle already consumes bit 0, so both start one step in
  assign a_next = a_mux_sel ? (a_reg << 1) : {31'b0, a_mag, 1'b0};
  assign b_next = b_mux_sel ? (b_reg >> 1) : {1'b0, b_mag[31:1]};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
  end

  // ------------------------------------------------------------
  // partial product and operand signs
  // ------------------------------------------------------------

  // bit 0 of b decides the seed
  assign prod_seed = b_mag[0] ? {32'b0, a_mag} : '0;
  assign prod_acc  = b_reg[0] ? (prod_reg + a_reg) : prod_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_reg   <= '0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load_cycle) begin
      prod_reg   <= prod_seed;
      sign_a_reg <= a[31];
      sign_b_reg <= b[31];
    end else if (calc_cycle) begin
      prod_reg <= prod_acc;
    end
  end

  // negate when exactly one operand was negative
  assign mul_result = (sign_a_reg ^ sign_b_reg) ? (~prod_reg + 64'd1) : prod_reg;

endmodule

/* imuldiv_div_ctrl.sv */
// divider control, one operation at a time
// accept edge loads operands, then 32 shift/subtract cycles, then hold in DONE
module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic div_req_val,
  output logic div_req_rdy,
  output logic div_resp_val,
  input  logic div_resp_rdy,
  output logic load,
  output logic step
);
  import imuldiv_pkg::*;

  iter_state_t state;
  logic [4:0]  count;
  logic        req_go;
  logic        resp_go;

  assign req_go  = div_req_val & div_req_rdy;
  assign resp_go = div_resp_val & div_resp_rdy;

  // ------------------------------------------------------------
  // state and step count
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // one quotient bit per step, 32 steps
          if (count == 5'd31) begin
            state <= ST_DONE;
          end else begin
            count <= count + 5'd1;
          end
        end
        ST_DONE: begin
          // wait here until the dispatcher lets the response out
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  always_comb begin
    div_req_rdy  = 1'b0;
    div_resp_val = 1'b0;
    load         = 1'b0;
    step         = 1'b0;
    case (state)
      ST_IDLE: begin
        div_req_rdy = 1'b1;
        load        = req_go;
      end
      ST_CALC: step = 1'b1;
      ST_DONE: div_resp_val = 1'b1;
      default: div_req_rdy = 1'b0;
    endcase
  end

endmodule

/* imuldiv_div_dpath.sv */
// restoring 32-bit divider on magnitudes, signed or unsigned per request
// x/0 gives quotient all ones and the dividend as remainder
module imuldiv_div_dpath (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  a,
  input  imuldiv_pkg::word_t  b,
  input  logic                div_signed,
  input  logic                load,
  input  logic                step,
  output imuldiv_pkg::dword_t div_result
);
  import imuldiv_pkg::*;

  // signs only count for a signed divide
  logic        sign_a;
  logic        sign_b;
  word_t       a_mag;
  word_t       b_mag;

  // remainder in [63:32], quotient bits shift in at [0]
  dword_t      rq_reg;
  word_t       divisor_reg;
  word_t       dividend_reg;
  logic        neg_quot_reg;
  logic        neg_rem_reg;
  logic        div_zero_reg;

  logic [32:0] rem_shift;
  logic [32:0] diff;
  dword_t      rq_next;
  word_t       quot;
  word_t       rem;

  assign sign_a = div_signed & a[31];
  assign sign_b = div_signed & b[31];
  assign a_mag  = sign_a ? (~a + 32'd1) : a;
  assign b_mag  = sign_b ? (~b + 32'd1) : b;

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------

  // shifted remainder needs 33 bits before the trial subtract
  assign rem_shift = rq_reg[63:31];
  assign diff      = rem_shift - {1'b0, divisor_reg};

  // borrow out means restore and shift in a 0
  assign rq_next = diff[32] ? {rq_reg[62:0], 1'b0}
                            : {diff[31:0], rq_reg[30:0], 1'b1};

  // divisor and raw dividend only matter between load and DONE
  always_ff @(posedge clk) begin
    if (load) begin
      divisor_reg  <= b_mag;
      dividend_reg <= a;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_reg       <= '0;
      neg_quot_reg <= 1'b0;
      neg_rem_reg  <= 1'b0;
      div_zero_reg <= 1'b0;
    end else if (load) begin
      rq_reg       <= {32'b0, a_mag};
      neg_quot_reg <= sign_a ^ sign_b;
      neg_rem_reg  <= sign_a;
      div_zero_reg <= (b == '0);
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  // ------------------------------------------------------------
  // sign fix and zero divisor
  // ------------------------------------------------------------

  // quotient sign follows both operands, remainder follows the dividend
  // 0x80000000 / -1 wraps back to 0x80000000 here
  assign quot = neg_quot_reg ? (~rq_reg[31:0] + 32'd1) : rq_reg[31:0];
  assign rem  = neg_rem_reg ? (~rq_reg[63:32] + 32'd1) : rq_reg[63:32];

  assign div_result = div_zero_reg ? {dividend_reg, 32'hffff_ffff} : {rem, quot};

endmodule

/* imuldiv_dispatch.sv */
// steers requests to the mul or div unit and returns responses in order
// a full tag queue stalls requests even when a pop happens the same cycle
module imuldiv_dispatch #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  input  imuldiv_pkg::fn_t    req_fn,
  output logic                req_rdy,
  output logic                mul_req_val,
  input  logic                mul_req_rdy,
  output logic                div_req_val,
  input  logic                div_req_rdy,
  output logic                div_signed,
  input  logic                mul_resp_val,
  output logic                mul_resp_rdy,
  input  imuldiv_pkg::dword_t mul_result,
  input  logic                div_resp_val,
  output logic                div_resp_rdy,
  input  imuldiv_pkg::dword_t div_result,
  output logic                resp_val,
  input  logic                resp_rdy,
  output imuldiv_pkg::dword_t resp_result
);
  import imuldiv_pkg::*;

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  // one tag bit per entry, 1 for the divider
  logic [ORDER_DEPTH-1:0] tag_mem;
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       used;

  logic to_div;
  logic unit_rdy;
  logic full;
  logic empty;
  logic head_div;
  logic push;
  logic pop;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------
  always_comb begin
    to_div     = 1'b1;
    div_signed = 1'b0;
    case (req_fn)
      FN_MUL:  to_div = 1'b0;
      FN_DIV:  div_signed = 1'b1;
      FN_DIVU: div_signed = 1'b0;
      default: div_signed = 1'b0;
    endcase
  end

  assign full  = (used == CNT_W'(ORDER_DEPTH));
  assign empty = (used == '0);

  // ready only when the addressed unit is idle and a tag slot is free
  assign unit_rdy    = to_div ? div_req_rdy : mul_req_rdy;
  assign req_rdy     = unit_rdy & ~full;
  assign mul_req_val = req_val & ~to_div & ~full;
  assign div_req_val = req_val & to_div & ~full;
  assign push        = req_val & req_rdy;

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------
  assign head_div     = tag_mem[rd_ptr];
  assign resp_val     = ~empty & (head_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_div ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy & ~empty & ~head_div;
  assign div_resp_rdy = resp_rdy & ~empty & head_div;
  assign pop          = resp_val & resp_rdy;

  // ------------------------------------------------------------
  // tag queue
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr] <= to_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy moves only when exactly one side acts
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

/* imuldiv_iterative.sv */
// iterative multiply/divide unit, one op in flight per unit
// FN_MUL answers 32 cycles after accept and divides 33, without back-pressure
module imuldiv_iterative #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);
  import imuldiv_pkg::*;

  // dispatcher to units
  logic   mul_req_val;
  logic   mul_req_rdy;
  logic   div_req_val;
  logic   div_req_rdy;
  logic   div_signed;
  logic   mul_resp_val;
  logic   mul_resp_rdy;
  logic   div_resp_val;
  logic   div_resp_rdy;
  dword_t mul_result;
  dword_t div_result;
  dword_t resp_result;

  // ctrl to dpath
  logic   a_en;
  logic   a_mux_sel;
  logic   b_en;
  logic   b_mux_sel;
  logic   load;
  logic   step;

  assign resp = '{result: resp_result};

  // ------------------------------------------------------------
  // routing and ordering
  // ------------------------------------------------------------
  imuldiv_dispatch #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) dispatch_inst (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_fn       (req.fn),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_signed   (div_signed),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_result   (mul_result),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_result   (div_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_result  (resp_result)
  );

  // ------------------------------------------------------------
  // multiplier
  // ------------------------------------------------------------
  imuldiv_mul_ctrl mul_ctrl_inst (
    .clk          (clk),
    .reset        (reset),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .a_en         (a_en),
    .a_mux_sel    (a_mux_sel),
    .b_en         (b_en),
    .b_mux_sel    (b_mux_sel)
  );

  // operands come straight from the request
  imuldiv_mul_dpath mul_dpath_inst (
    .clk        (clk),
    .reset      (reset),
    .a          (req.a),
    .b          (req.b),
    .a_en       (a_en),
    .a_mux_sel  (a_mux_sel),
    .b_en       (b_en),
    .b_mux_sel  (b_mux_sel),
    .mul_result (mul_result)
  );

  // ------------------------------------------------------------
  // divider
  // ------------------------------------------------------------
  imuldiv_div_ctrl div_ctrl_inst (
    .clk          (clk),
    .reset        (reset),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .load         (load),
    .step         (step)
  );

  imuldiv_div_dpath div_dpath_inst (
    .clk        (clk),
    .reset      (reset),
    .a          (req.a),
    .b          (req.b),
    .div_signed (div_signed),
    .load       (load),
    .step       (step),
    .div_result (div_result)
  );

endmodule

/* imuldiv_iterative_tb.sv */
// testbench for the iterative multiply/divide unit
// inputs change on the falling edge, outputs are sampled on the rising edge
// latency is checked only for ops issued with both units idle and resp_rdy high
module imuldiv_iterative_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import imuldiv_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_RAND   = 40;
  localparam int NUM_ZERO   = 8;
  localparam int NUM_MIX    = 200;
  // corners, random and zero divisor ops, the ordering pair, the busy probe op, then the mix
  localparam int NUM_OPS    = 25 + NUM_RAND + 2 * (25 + NUM_RAND + NUM_ZERO) + 3 + NUM_MIX;
  localparam int LIMIT      = (NUM_OPS * 40 + 600) * CLK_PERIOD;

  localparam word_t CORNERS [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  logic         clk = 1'b0;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy;

  // scoreboard, one entry per accepted request
  dword_t       exp_q [$];
  int           cyc_q [$];
  int           lat_q [$];
  int           cycle;
  int           acc_count;
  int           resp_count;
  int           lat;
  logic         check_lat;
  string        test_name;
  word_t        rng_state = 32'h7249_4570;

  always #(CLK_PERIOD / 2) clk = ~clk;

  imuldiv_iterative #(
    .ORDER_DEPTH (2)
  ) imuldiv_iterative_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // ------------------------------------------------------------
  // failure reporting
  // ------------------------------------------------------------
  task automatic stop_with_fail();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_value(input string name, input dword_t expected, input dword_t actual);
    $display("Fail %s expected %h actual %h", name, expected, actual);
    stop_with_fail();
  endtask

  task automatic report_text(input string what);
    $display("Error: %s", what);
    stop_with_fail();
  endtask

  // ------------------------------------------------------------
  // random numbers and reference model
  // ------------------------------------------------------------
  function automatic word_t xorshift(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // signed 64-bit product, truncating divide, x/0 keeps the dividend
  function automatic dword_t model(input fn_t fn, input word_t a, input word_t b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    dword_t          q;
    dword_t          r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    if (fn == FN_MUL) begin
      return sa * sb;
    end else if (b == '0) begin
      return {a, 32'hffff_ffff};
    end else if (fn == FN_DIV) begin
      // 64-bit math so that 0x80000000 / -1 does not overflow
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = ua / ub;
      r = ua % ub;
    end
    return {r[31:0], q[31:0]};
  endfunction

  // ------------------------------------------------------------
  // monitor and checks
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset) begin
      // pop before push, a response always belongs to an older request
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          report_text("response arrived with no request outstanding");
        end else begin
          assert (resp.result == exp_q[0])
            else report_value(test_name, exp_q[0], resp.result);
          lat = cycle - cyc_q[0];
          assert (lat_q[0] == 0 || lat == lat_q[0])
            else report_value({test_name, " latency"}, lat_q[0], lat);
          void'(exp_q.pop_front());
          void'(cyc_q.pop_front());
          void'(lat_q.pop_front());
          resp_count++;
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(model(req.fn, req.a, req.b));
        cyc_q.push_back(cycle);
        // 0 means no latency check for this op
        lat_q.push_back(!check_lat ? 0 : (req.fn == FN_MUL) ? 32 : 33);
        acc_count++;
      end
    end
    cycle++;
  end

  // one cycle after reset the unit is idle and empty
  reset_state: assert property (@(posedge clk) reset |=> (!resp_val && req_rdy))
    else report_value("reset state", 64'h1, {62'b0, $sampled(resp_val), $sampled(req_rdy)});

  // a held response must not move
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp.result))
    else report_text("resp changed while resp_val was high and resp_rdy low");

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  task automatic send_req(input fn_t fn, input word_t a, input word_t b);
    @(negedge clk);
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // one op at a time, wait for its response
  task automatic run_op(input fn_t fn, input word_t a, input word_t b);
    int n;
    n = resp_count;
    send_req(fn, a, b);
    while (resp_count == n) @(negedge clk);
  endtask

  task automatic run_random_mix(input int n);
    int    issued;
    logic  accepted;
    word_t r;
    issued   = 0;
    accepted = 1'b0;
    while (issued < n) begin
      @(negedge clk);
      if (accepted) req_val = 1'b0;
      r = rand_word();
      resp_rdy = r[0];
      // a pending request is held until it is taken
      if (!req_val && r[2:1] != 2'b00) begin
        req.fn  = (r[5:4] == 2'd3) ? FN_MUL : fn_t'(r[5:4]);
        req.a   = rand_word();
        req.b   = (r[11:8] == 4'd0) ? '0 : rand_word();
        req_val = 1'b1;
      end
      @(posedge clk);
      accepted = req_val && req_rdy;
      if (accepted) issued++;
    end
    @(negedge clk);
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    // both units back in idle means every accepted op has left the DUT
    while (!(imuldiv_iterative_inst.mul_req_rdy && imuldiv_iterative_inst.div_req_rdy)) begin
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    fn_t fn;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    reset      = 1'b1;
    check_lat  = 1'b0;
    cycle      = 0;
    acc_count  = 0;
    resp_count = 0;
    test_name  = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (!resp_val && req_rdy)
      else report_value("reset", 64'h1, {62'b0, resp_val, req_rdy});

    // serial ops with resp_rdy high, latency is exact
    resp_rdy  = 1'b1;
    check_lat = 1'b1;
    test_name = "mul corners";
    foreach (CORNERS[i]) foreach (CORNERS[j]) run_op(FN_MUL, CORNERS[i], CORNERS[j]);
    test_name = "mul random";
    repeat (NUM_RAND) run_op(FN_MUL, rand_word(), rand_word());

    for (int k = 0; k < 2; k++) begin
      fn = (k == 0) ? FN_DIV : FN_DIVU;
      test_name = (k == 0) ? "div corners" : "divu corners";
      foreach (CORNERS[i]) foreach (CORNERS[j]) run_op(fn, CORNERS[i], CORNERS[j]);
      test_name = (k == 0) ? "div random" : "divu random";
      repeat (NUM_RAND) run_op(fn, rand_word(), rand_word());
      test_name = (k == 0) ? "div by zero" : "divu by zero";
      repeat (NUM_ZERO) run_op(fn, rand_word(), '0);
    end

    // div then mul with the response side stalled
    check_lat = 1'b0;
    test_name = "ordering";
    resp_rdy  = 1'b0;
    send_req(FN_DIV, rand_word(), 32'h0000_0007);
    send_req(FN_MUL, rand_word(), rand_word());
    while (!(imuldiv_iterative_inst.mul_resp_val && imuldiv_iterative_inst.div_resp_val)) begin
      @(negedge clk);
    end
    resp_rdy = 1'b1;
    while (exp_q.size() != 0) @(negedge clk);

    // second mul while the first computes, a tag slot is still free
    test_name = "busy mul";
    send_req(FN_MUL, rand_word(), rand_word());
    @(negedge clk);
    req.fn  = FN_MUL;
    req_val = 1'b1;
    @(posedge clk);
    assert (!req_rdy)
      else report_value("busy mul refuse", 64'h0, {63'b0, req_rdy});
    @(negedge clk);
    req_val = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);

    test_name = "random mix";
    run_random_mix(NUM_MIX);
    assert (resp_count == acc_count)
      else report_value("random mix count", acc_count, resp_count);

    repeat (4) @(negedge clk);
    if (resp_count == acc_count && exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_text("responses left over at the end of the run");
    end
  end

  // watchdog sized from the op count, about 40 cycles per op
  initial begin
    #(LIMIT);
    report_text("timeout, the DUT stopped answering");
  end

endmodule

/* imuldiv.f */
imuldiv_pkg.sv
imuldiv_mul_ctrl.sv
imuldiv_mul_dpath.sv
imuldiv_div_ctrl.sv
imuldiv_div_dpath.sv
imuldiv_dispatch.sv
imuldiv_iterative.sv
imuldiv_iterative_tb.sv

/* Makefile */
# Verilator flow for the iterative multiply/divide unit

VERILATOR  ?= verilator
FILELIST   := imuldiv.f
TOP        := imuldiv_iterative_tb
RTL_TOP    := imuldiv_iterative
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -xF '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
